// ==== filelist.f ====
+incdir+source
source/exec_pkg.sv
source/add_sub_unit.sv
source/mov_unit.sv
source/gpr_cdb_arbiter.sv
source/exec_cluster.sv
testbench/exec_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: exec_cluster

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/exec_pkg.sv
      - source/add_sub_unit.sv
      - source/mov_unit.sv
      - source/gpr_cdb_arbiter.sv
      - source/exec_cluster.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/exec_cluster_tb.sv

// ==== testbench/exec_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module exec_cluster_tb;

	localparam int TAG_COUNT   = 1 << `EXEC_TAG_WIDTH;
	localparam int INSTR_COUNT = 200;
	localparam int CYCLE_LIMIT = INSTR_COUNT * 40 + 100;

	logic clk;
	logic reset;
	logic add_sub_issue_valid;
	logic add_sub_sub;
	exec_pkg::tag_t add_sub_dest_tag;
	logic a_ready;
	exec_pkg::tag_t a_tag;
	exec_pkg::data_t a_data;
	logic b_ready;
	exec_pkg::tag_t b_tag;
	exec_pkg::data_t b_data;
	logic mov_issue_valid;
	logic mov_use_imm;
	exec_pkg::data_t mov_imm;
	exec_pkg::tag_t mov_dest_tag;
	logic src_ready;
	exec_pkg::tag_t src_tag;
	exec_pkg::data_t src_data;
	logic add_sub_issue_ready;
	logic mov_issue_ready;
	logic cdb_valid;
	exec_pkg::tag_t cdb_tag;
	exec_pkg::data_t cdb_data;

	exec_cluster i_exec_cluster (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// random source and model state
	////////////////////////////////////////////////////////////

	logic [15:0] lfsr = 16'd9179;

	// tag table
	logic in_flight [TAG_COUNT];
	logic exp_known [TAG_COUNT];
	logic fast_path [TAG_COUNT];
	exec_pkg::data_t exp_val [TAG_COUNT];
	int issue_cyc [TAG_COUNT];

	// one entry per unit
	logic as_busy;
	logic as_sub;
	exec_pkg::tag_t as_dest;
	logic as_a_known;
	logic as_b_known;
	exec_pkg::tag_t as_a_tag;
	exec_pkg::tag_t as_b_tag;
	exec_pkg::data_t as_a_val;
	exec_pkg::data_t as_b_val;
	logic mv_busy;
	exec_pkg::tag_t mv_dest;
	logic mv_known;
	exec_pkg::tag_t mv_tag;
	exec_pkg::data_t mv_val;

	logic bus_valid;
	exec_pkg::tag_t bus_tag;
	exec_pkg::data_t bus_val;
	exec_pkg::tag_t cand [TAG_COUNT + 1];
	int n_cand;
	logic prio_pending;
	exec_pkg::tag_t prio_tag;
	int cycle;
	int issued;
	int broadcasts;
	int checks;
	int errors;

	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_result(input exec_pkg::tag_t tag, input exec_pkg::data_t got,
			input exec_pkg::data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: tag %0d carries %h, expected %h", $time, tag, got, exp);
		end
	endtask

	task automatic check_tag_known(input exec_pkg::tag_t tag);
		checks++;
		if (!in_flight[tag]) begin
			errors++;
			$display("** Error at %0t: tag %0d broadcast but not in flight", $time, tag);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// model
	////////////////////////////////////////////////////////////

	task automatic complete_entries();
		if (as_busy && as_a_known && as_b_known && !exp_known[as_dest]) begin
			exp_val[as_dest]   = as_sub ? as_a_val - as_b_val : as_a_val + as_b_val;
			exp_known[as_dest] = 1'b1;
		end
		if (mv_busy && mv_known && !exp_known[mv_dest]) begin
			exp_val[mv_dest]   = mv_val;
			exp_known[mv_dest] = 1'b1;
		end
	endtask

	task automatic handle_broadcast(input exec_pkg::tag_t t, input exec_pkg::data_t d);
		exec_pkg::data_t v;
		v = exp_val[t];
		check_tag_known(t);
		if (in_flight[t] && !exp_known[t]) begin
			errors++;
			$display("tag %0d was broadcast before its operands were known", t);
		end else if (in_flight[t]) begin
			check_result(t, d, v);
		end
		if (in_flight[t] && fast_path[t])
			check_flag(cycle == issue_cyc[t] + 2, 1'b1, "two cycle latency");
		in_flight[t] = 1'b0;
		exp_known[t] = 1'b0;
		fast_path[t] = 1'b0;
		bus_val = v;
		broadcasts++;
		// waiting operands snoop the bus
		if (as_busy) begin
			if (!as_a_known && as_a_tag == t) begin
				as_a_known = 1'b1;
				as_a_val   = v;
			end
			if (!as_b_known && as_b_tag == t) begin
				as_b_known = 1'b1;
				as_b_val   = v;
			end
			if (as_dest == t)
				as_busy = 1'b0;
		end
		if (mv_busy) begin
			if (!mv_known && mv_tag == t) begin
				mv_known = 1'b1;
				mv_val   = v;
			end
			if (mv_dest == t)
				mv_busy = 1'b0;
		end
		complete_entries();
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	function automatic exec_pkg::tag_t alloc_tag();
		logic [31:0] r;
		exec_pkg::tag_t t;
		r = rand_bits(`EXEC_TAG_WIDTH);
		t = r[`EXEC_TAG_WIDTH-1:0];
		while (in_flight[t])
			t = t + 1'b1;
		return t;
	endfunction

	// ready with random data, or waiting on an in-flight tag
	task automatic pick_operand(output logic rdy, output exec_pkg::tag_t tg,
			output exec_pkg::data_t dat, output logic known, output exec_pkg::tag_t wait_tag,
			output exec_pkg::data_t val);
		logic [31:0] r;
		dat = rand_bits(32);
		r   = rand_bits(`EXEC_TAG_WIDTH);
		if (n_cand == 0 || lfsr_bit()) begin
			rdy   = 1'b1;
			tg    = r[`EXEC_TAG_WIDTH-1:0];
			known = 1'b1;
			val   = dat;
		end else begin
			r   = rand_bits(5);
			rdy = 1'b0;
			tg  = cand[r % n_cand];
			// tag on the bus at the issue edge
			known = bus_valid && tg == bus_tag;
			val   = known ? bus_val : '0;
		end
		wait_tag = tg;
	endtask

	task automatic start_tag(input exec_pkg::tag_t t, input logic fast);
		in_flight[t] = 1'b1;
		exp_known[t] = 1'b0;
		fast_path[t] = fast;
		issue_cyc[t] = cycle;
		issued++;
		complete_entries();
	endtask

	task automatic issue_add_sub();
		exec_pkg::tag_t t;
		t = alloc_tag();
		add_sub_issue_valid = 1'b1;
		add_sub_sub         = lfsr_bit();
		add_sub_dest_tag    = t;
		pick_operand(a_ready, a_tag, a_data, as_a_known, as_a_tag, as_a_val);
		pick_operand(b_ready, b_tag, b_data, as_b_known, as_b_tag, as_b_val);
		as_busy = 1'b1;
		as_sub  = add_sub_sub;
		as_dest = t;
		start_tag(t, a_ready && b_ready);
	endtask

	task automatic issue_mov();
		exec_pkg::tag_t t;
		logic fast;
		logic [31:0] r;
		t = alloc_tag();
		mov_issue_valid = 1'b1;
		mov_dest_tag    = t;
		mov_use_imm     = lfsr_bit();
		mov_imm         = rand_bits(32);
		if (mov_use_imm) begin
			// source fields are noise here
			src_ready = lfsr_bit();
			r         = rand_bits(`EXEC_TAG_WIDTH);
			src_tag   = r[`EXEC_TAG_WIDTH-1:0];
			src_data  = rand_bits(32);
			mv_known  = 1'b1;
			mv_val    = mov_imm;
			fast      = 1'b1;
		end else begin
			pick_operand(src_ready, src_tag, src_data, mv_known, mv_tag, mv_val);
			fast = src_ready;
		end
		mv_busy = 1'b1;
		mv_dest = t;
		start_tag(t, fast && !as_busy);
	endtask

	task automatic step_cycle();
		bus_valid = cdb_valid;
		bus_tag   = cdb_tag;
		if (prio_pending) begin
			check_flag(cdb_valid, 1'b1, "cdb_valid after double request");
			check_flag(cdb_tag == prio_tag, 1'b1, "add/sub tag first");
			prio_pending = 1'b0;
		end
		if (cdb_valid)
			handle_broadcast(cdb_tag, cdb_data);
		check_flag(add_sub_issue_ready, !as_busy, "add_sub_issue_ready");
		check_flag(mov_issue_ready, !mv_busy, "mov_issue_ready");
		if (i_exec_cluster.add_sub_req && i_exec_cluster.mov_req) begin
			prio_pending = 1'b1;
			prio_tag     = as_dest;
		end
		n_cand = 0;
		for (int i = 0; i < TAG_COUNT; i++) begin
			if (in_flight[i]) begin
				cand[n_cand] = exec_pkg::tag_t'(i);
				n_cand++;
			end
		end
		if (bus_valid) begin
			cand[n_cand] = bus_tag;
			n_cand++;
		end
		// a busy unit may see issue_valid held high
		if (add_sub_issue_ready) begin
			add_sub_issue_valid = 1'b0;
			if (issued < INSTR_COUNT && lfsr_bit())
				issue_add_sub();
		end else if (add_sub_issue_valid) begin
			add_sub_issue_valid = lfsr_bit();
		end
		if (mov_issue_ready) begin
			mov_issue_valid = 1'b0;
			if (issued < INSTR_COUNT && lfsr_bit())
				issue_mov();
		end else if (mov_issue_valid) begin
			mov_issue_valid = lfsr_bit();
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int drain;
		logic timed_out;
		reset = 1'b1;
		add_sub_issue_valid = 1'b0;
		add_sub_sub = 1'b0;
		add_sub_dest_tag = '0;
		a_ready = 1'b0;
		a_tag = '0;
		a_data = '0;
		b_ready = 1'b0;
		b_tag = '0;
		b_data = '0;
		mov_issue_valid = 1'b0;
		mov_use_imm = 1'b0;
		mov_imm = '0;
		mov_dest_tag = '0;
		src_ready = 1'b0;
		src_tag = '0;
		src_data = '0;
		for (int i = 0; i < TAG_COUNT; i++) begin
			in_flight[i] = 1'b0;
			exp_known[i] = 1'b0;
			fast_path[i] = 1'b0;
			exp_val[i] = '0;
			issue_cyc[i] = 0;
		end
		as_busy = 1'b0;
		mv_busy = 1'b0;
		prio_pending = 1'b0;
		cycle = 0;
		issued = 0;
		broadcasts = 0;
		checks = 0;
		errors = 0;
		drain = 0;
		timed_out = 1'b0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_flag(cdb_valid, 1'b0, "cdb_valid after reset");
		check_flag(add_sub_issue_ready, 1'b1, "add_sub_issue_ready after reset");
		check_flag(mov_issue_ready, 1'b1, "mov_issue_ready after reset");

		while (drain < 8 && !timed_out) begin
			@(negedge clk);
			cycle++;
			step_cycle();
			if (issued == INSTR_COUNT && broadcasts == issued)
				drain++;
			if (cycle > CYCLE_LIMIT)
				timed_out = 1'b1;
		end

		if (timed_out) begin
			$display("timeout after %0d cycles, %0d of %0d issued tags broadcast",
				cycle, broadcasts, issued);
			$display("Testbench failed");
		end else begin
			for (int i = 0; i < TAG_COUNT; i++) begin
				if (in_flight[i]) begin
					errors++;
					$display("tag %0d was issued but never broadcast", i);
				end
			end
			if (broadcasts != issued) begin
				errors++;
				$display("%0d tags issued but %0d broadcasts seen", issued, broadcasts);
			end
			$display("checks %0d, errors %0d, issued %0d, broadcasts %0d",
				checks, errors, issued, broadcasts);
			if (errors == 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/exec_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module exec_cluster (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            add_sub_issue_valid,
	input  wire logic            add_sub_sub,
	input  wire exec_pkg::tag_t  add_sub_dest_tag,
	input  wire logic            a_ready,
	input  wire exec_pkg::tag_t  a_tag,
	input  wire exec_pkg::data_t a_data,
	input  wire logic            b_ready,
	input  wire exec_pkg::tag_t  b_tag,
	input  wire exec_pkg::data_t b_data,
	input  wire logic            mov_issue_valid,
	input  wire logic            mov_use_imm,
	input  wire exec_pkg::data_t mov_imm,
	input  wire exec_pkg::tag_t  mov_dest_tag,
	input  wire logic            src_ready,
	input  wire exec_pkg::tag_t  src_tag,
	input  wire exec_pkg::data_t src_data,
	output logic                 add_sub_issue_ready,
	output logic                 mov_issue_ready,
	output logic                 cdb_valid,
	output exec_pkg::tag_t       cdb_tag,
	output exec_pkg::data_t      cdb_data
);
	logic add_sub_req;
	logic add_sub_grant;
	exec_pkg::tag_t add_sub_tag;
	exec_pkg::data_t add_sub_data;
	logic mov_req;
	logic mov_grant;
	exec_pkg::tag_t mov_tag;
	exec_pkg::data_t mov_data;

	// bus loops back into both stations
	add_sub_unit i_add_sub_unit (
		.clk,
		.reset,
		.issue_valid(add_sub_issue_valid),
		.sub(add_sub_sub),
		.dest_tag(add_sub_dest_tag),
		.a_ready,
		.a_tag,
		.a_data,
		.b_ready,
		.b_tag,
		.b_data,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.grant(add_sub_grant),
		.issue_ready(add_sub_issue_ready),
		.cdb_req(add_sub_req),
		.result_tag(add_sub_tag),
		.result_data(add_sub_data)
	);

	mov_unit i_mov_unit (
		.clk,
		.reset,
		.issue_valid(mov_issue_valid),
		.use_imm(mov_use_imm),
		.imm(mov_imm),
		.dest_tag(mov_dest_tag),
		.src_ready,
		.src_tag,
		.src_data,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.grant(mov_grant),
		.issue_ready(mov_issue_ready),
		.cdb_req(mov_req),
		.result_tag(mov_tag),
		.result_data(mov_data)
	);

	gpr_cdb_arbiter i_gpr_cdb_arbiter (
		.clk,
		.reset,
		.add_sub_req,
		.mov_req,
		.add_sub_tag,
		.add_sub_data,
		.mov_tag,
		.mov_data,
		.add_sub_grant,
		.mov_grant,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

`default_nettype wire

// ==== source/gpr_cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module gpr_cdb_arbiter (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            add_sub_req,
	input  wire logic            mov_req,
	input  wire exec_pkg::tag_t  add_sub_tag,
	input  wire exec_pkg::data_t add_sub_data,
	input  wire exec_pkg::tag_t  mov_tag,
	input  wire exec_pkg::data_t mov_data,
	output logic                 add_sub_grant,
	output logic                 mov_grant,
	output logic                 cdb_valid,
	output exec_pkg::tag_t       cdb_tag,
	output exec_pkg::data_t      cdb_data
);
	logic rsv_valid;
	exec_pkg::cdb_source_t rsv_source;

	////////////////////////////////////////////////////////////
	// grant
	////////////////////////////////////////////////////////////

	// add/sub wins, mov only on an otherwise free slot
	assign add_sub_grant = add_sub_req;
	assign mov_grant     = mov_req && !add_sub_req;

	////////////////////////////////////////////////////////////
	// reservation
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			rsv_valid  <= 1'b0;
			rsv_source <= exec_pkg::CDB_ADD_SUB;
		end else begin
			rsv_valid <= add_sub_grant || mov_grant;
			if (add_sub_grant)
				rsv_source <= exec_pkg::CDB_ADD_SUB;
			else if (mov_grant)
				rsv_source <= exec_pkg::CDB_MOV;
		end
	end

	////////////////////////////////////////////////////////////
	// bus drive
	////////////////////////////////////////////////////////////

	// units latched their result on the grant edge
	always_comb begin
		cdb_valid = rsv_valid;
		case (rsv_source)
			exec_pkg::CDB_ADD_SUB: begin
				cdb_tag  = add_sub_tag;
				cdb_data = add_sub_data;
			end
			default: begin
				cdb_tag  = mov_tag;
				cdb_data = mov_data;
			end
		endcase
	end

	// one owner per slot
	one_grant: assert property (@(posedge clk) disable iff (reset)
		!(add_sub_grant && mov_grant));

endmodule

`default_nettype wire

// ==== source/mov_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module mov_unit (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            issue_valid,
	input  wire logic            use_imm,
	input  wire exec_pkg::data_t imm,
	input  wire exec_pkg::tag_t  dest_tag,
	input  wire logic            src_ready,
	input  wire exec_pkg::tag_t  src_tag,
	input  wire exec_pkg::data_t src_data,
	input  wire logic            cdb_valid,
	input  wire exec_pkg::tag_t  cdb_tag,
	input  wire exec_pkg::data_t cdb_data,
	input  wire logic            grant,
	output logic                 issue_ready,
	output logic                 cdb_req,
	output exec_pkg::tag_t       result_tag,
	output exec_pkg::data_t      result_data
);
	exec_pkg::unit_state_t state;
	logic src_have;
	exec_pkg::tag_t dest_q;
	exec_pkg::tag_t src_tag_q;
	exec_pkg::data_t val_q;

	logic idle;
	logic issue;
	logic src_cur;
	logic src_hit;
	logic src_have_next;
	exec_pkg::data_t val_next;

	assign idle        = state == exec_pkg::UNIT_IDLE;
	assign issue_ready = idle;
	assign cdb_req     = state == exec_pkg::UNIT_DONE;
	assign issue       = issue_valid && issue_ready;

	// an immediate is complete at issue
	assign src_cur       = idle ? (use_imm || src_ready) : src_have;
	assign src_hit       = cdb_valid && !src_cur && cdb_tag == (idle ? src_tag : src_tag_q);
	assign src_have_next = src_cur || src_hit;
	assign val_next      = src_hit ? cdb_data : idle ? (use_imm ? imm : src_data) : val_q;

	////////////////////////////////////////////////////////////
	// entry state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= exec_pkg::UNIT_IDLE;
			src_have <= 1'b0;
		end else begin
			case (state)
				exec_pkg::UNIT_IDLE: begin
					if (issue) begin
						src_have <= src_have_next;
						state    <= src_have_next ? exec_pkg::UNIT_DONE : exec_pkg::UNIT_WAIT;
					end
				end
				exec_pkg::UNIT_WAIT: begin
					src_have <= src_have_next;
					if (src_have_next)
						state <= exec_pkg::UNIT_DONE;
				end
				exec_pkg::UNIT_DONE: begin
					if (grant)
						state <= exec_pkg::UNIT_IDLE;
				end
				default: state <= exec_pkg::UNIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			dest_q    <= dest_tag;
			src_tag_q <= src_tag;
		end
		if (issue || state == exec_pkg::UNIT_WAIT)
			val_q <= val_next;
		if (grant) begin
			result_tag  <= dest_q;
			result_data <= val_q;
		end
	end

	grant_in_done: assert property (@(posedge clk) disable iff (reset)
		grant |-> state == exec_pkg::UNIT_DONE);

endmodule

`default_nettype wire

// ==== source/add_sub_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exec_params.svh"

module add_sub_unit (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            issue_valid,
	input  wire logic            sub,
	input  wire exec_pkg::tag_t  dest_tag,
	input  wire logic            a_ready,
	input  wire exec_pkg::tag_t  a_tag,
	input  wire exec_pkg::data_t a_data,
	input  wire logic            b_ready,
	input  wire exec_pkg::tag_t  b_tag,
	input  wire exec_pkg::data_t b_data,
	input  wire logic            cdb_valid,
	input  wire exec_pkg::tag_t  cdb_tag,
	input  wire exec_pkg::data_t cdb_data,
	input  wire logic            grant,
	output logic                 issue_ready,
	output logic                 cdb_req,
	output exec_pkg::tag_t       result_tag,
	output exec_pkg::data_t      result_data
);
	exec_pkg::unit_state_t state;
	logic a_have;
	logic b_have;
	logic sub_q;
	exec_pkg::tag_t dest_q;
	exec_pkg::tag_t a_tag_q;
	exec_pkg::tag_t b_tag_q;
	exec_pkg::data_t a_q;
	exec_pkg::data_t b_q;
	exec_pkg::data_t sum_q;

	logic issue;
	logic idle;
	logic a_have_next;
	logic b_have_next;
	logic enter_done;
	logic op_sub;
	exec_pkg::data_t a_next;
	exec_pkg::data_t b_next;

	assign idle        = state == exec_pkg::UNIT_IDLE;
	assign issue_ready = idle;
	assign cdb_req     = state == exec_pkg::UNIT_DONE;
	assign issue       = issue_valid && issue_ready;
	assign op_sub      = idle ? sub : sub_q;

	////////////////////////////////////////////////////////////
	// operand snooping
	////////////////////////////////////////////////////////////

	// idle looks at the incoming instruction, otherwise the held one
	always_comb begin
		logic a_cur;
		logic b_cur;
		logic a_hit;
		logic b_hit;
		a_cur  = idle ? a_ready : a_have;
		b_cur  = idle ? b_ready : b_have;
		a_hit  = cdb_valid && !a_cur && cdb_tag == (idle ? a_tag : a_tag_q);
		b_hit  = cdb_valid && !b_cur && cdb_tag == (idle ? b_tag : b_tag_q);
		a_have_next = a_cur || a_hit;
		b_have_next = b_cur || b_hit;
		a_next = a_hit ? cdb_data : (idle ? a_data : a_q);
		b_next = b_hit ? cdb_data : (idle ? b_data : b_q);
	end

	assign enter_done = (issue || state == exec_pkg::UNIT_WAIT) && a_have_next && b_have_next;

	////////////////////////////////////////////////////////////
	// entry state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= exec_pkg::UNIT_IDLE;
			a_have <= 1'b0;
			b_have <= 1'b0;
		end else begin
			if (issue || state == exec_pkg::UNIT_WAIT) begin
				a_have <= a_have_next;
				b_have <= b_have_next;
			end
			case (state)
				exec_pkg::UNIT_IDLE: begin
					if (issue)
						state <= enter_done ? exec_pkg::UNIT_DONE : exec_pkg::UNIT_WAIT;
				end
				exec_pkg::UNIT_WAIT: begin
					if (enter_done)
						state <= exec_pkg::UNIT_DONE;
				end
				exec_pkg::UNIT_DONE: begin
					if (grant)
						state <= exec_pkg::UNIT_IDLE;
				end
				default: state <= exec_pkg::UNIT_IDLE;
			endcase
		end
	end

	// held instruction and result
	always_ff @(posedge clk) begin
		if (issue) begin
			dest_q  <= dest_tag;
			sub_q   <= sub;
			a_tag_q <= a_tag;
			b_tag_q <= b_tag;
		end
		if (issue || state == exec_pkg::UNIT_WAIT) begin
			a_q <= a_next;
			b_q <= b_next;
		end
		if (enter_done)
			sum_q <= op_sub ? a_next - b_next : a_next + b_next;
		// bus reads this on the cycle after grant
		if (grant) begin
			result_tag  <= dest_q;
			result_data <= sum_q;
		end
	end

	grant_in_done: assert property (@(posedge clk) disable iff (reset)
		grant |-> state == exec_pkg::UNIT_DONE);

	// a busy entry ignores a held issue_valid
	busy_holds_entry: assert property (@(posedge clk) disable iff (reset)
		issue_valid && !idle |=> $stable(dest_q));

endmodule

`default_nettype wire

// ==== source/exec_pkg.sv ====
`default_nettype none
`include "exec_params.svh"

package exec_pkg;

	////////////////////////////////////////////////////////////
	// value types
	////////////////////////////////////////////////////////////

	// names the producing instruction
	typedef logic [`EXEC_TAG_WIDTH-1:0] tag_t;

	// register value on the bus and in the stations
	typedef logic [`EXEC_DATA_WIDTH-1:0] data_t;

	////////////////////////////////////////////////////////////
	// state encodings
	////////////////////////////////////////////////////////////

	// one reservation station entry
	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_WAIT,
		UNIT_DONE
	} unit_state_t;

	// owner of the reserved bus slot
	typedef enum logic [$clog2(`EXEC_CDB_SOURCES)-1:0] {
		CDB_ADD_SUB,
		CDB_MOV
	} cdb_source_t;

endpackage

`default_nettype wire

// ==== source/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

////////////////////////////////////////////////////////////
// execution cluster widths
////////////////////////////////////////////////////////////

// reorder buffer tag, 16 entries
`define EXEC_TAG_WIDTH 4

// general register value
`define EXEC_DATA_WIDTH 32

// units sharing the general register bus
`define EXEC_CDB_SOURCES 2

`endif
